// ==== Makefile ====
# Verilator build of the bus core testbench
# the run target fails when the simulation stops on $fatal

BIN := obj_dir/tb_top

.PHONY: build run clean

build:
	verilator --binary --assert --top-module tb_top -f all.f -o tb_top

run: build
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+bench
source/mc_pkg.sv
source/bus_master_arbiter.sv
source/io_page_decoder.sv
source/sd_card_arbiter.sv
source/vector_irq_ctrl.sv
source/mc_bus_top.sv
bench/tb_top.sv

// ==== bench/tb_tests.svh ====
/* directed tests of the bus core, one task per feature; each starts and
   ends on a falling clock edge */

`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

	// one read per device: window base, offset bits, device index
	localparam int N_DEC = 11;
	localparam logic [16:0] DEC_BASE [N_DEC] = '{
		17'o340000, 17'o000000, 17'o360000, 17'o177560, 17'o176500, 17'o177400,
		17'o177514, 17'o174000, 17'o177170, 17'o172140, 17'o176640};
	localparam int DEC_BITS [N_DEC] = '{13, 15, 13, 3, 3, 4, 2, 5, 2, 2, 3};
	localparam int DEC_DEV  [N_DEC] = '{0, 1, 1, 2, 3, 4, 5, 6, 7, 8, 9};

	// vectors in priority order, index 0 first
	localparam logic [15:0] IRQ_VECS [9] = '{
		16'o64, 16'o60, 16'o334, 16'o330, 16'o220, 16'o200, 16'o300, 16'o264, 16'o170};

	task automatic test_decode();
		mc_pkg::dev_vec_t stb, exp_stb;
		mc_pkg::wb_req_t  req;
		logic [16:0]      adr;
		logic [15:0]      rd;
		test_name = "decode";
		for (int k = 0; k < N_DEC; k++) begin
			adr = DEC_BASE[k] + 17'(take_bits(DEC_BITS[k] - 1) << 1);	// even word
			exp_stb = '0;
			exp_stb[DEC_DEV[k]] = 1'b1;
			cpu_access(adr, 1'b0, 2'b11, 16'h0000, stb, req, rd);
			check("bus address", 32'(adr), 32'(req.adr));
			check("select", 32'(exp_stb), 32'(stb));
			check("read data", 32'(16'(DEC_DEV[k] * 'o1000) + 16'(adr[8:1])), 32'(rd));
		end
	endtask

	task automatic test_byte_lanes();
		mc_pkg::dev_vec_t stb;
		mc_pkg::wb_req_t  req;
		logic [15:0]      rd, wd;
		test_name = "byte_lanes";
		for (int s = 0; s < 4; s++) begin
			wd = 16'(take_bits(16));
			cpu_access(17'o177562, 1'b1, 2'(s), wd, stb, req, rd);
			check("cpu sel", 32'(s), 32'(req.sel));	// passes untouched
			check("cpu write data", 32'(wd), 32'(req.dat));
			check("cpu we", 32'(1), 32'(req.we));
		end
		rk_dma = 1'b1;
		wait_gnt(1'b0);
		wd = 16'(take_bits(16));
		dma_cycle(1'b0, 17'(take_bits(14) << 1), 1'b1, 2'b01, wd, req, rd);
		rk_dma = 1'b0;
		check("dma sel", 32'(2'b11), 32'(req.sel));	// widened to a word
		check("dma write data", 32'(wd), 32'(req.dat));
		@(negedge wb_clk);
		check("cpu grant back", 32'(1), 32'(cpu_gnt));
	endtask

	task automatic test_arbitration();
		mc_pkg::wb_req_t req;
		logic [16:0]     adr;
		logic [15:0]     rd;
		test_name = "arbitration";
		@(negedge wb_clk);
		cpu_req     = '0;
		cpu_req.adr = 17'o170000;	// unmapped, cycle stays open
		cpu_req.cyc = 1'b1;
		cpu_req.stb = 1'b1;
		@(negedge wb_clk);
		rk_dma = 1'b1;
		my_dma = 1'b1;
		repeat (4) begin
			@(negedge wb_clk);
			check("rk grant in cpu cycle", 32'(0), 32'(rk_gnt));
			check("my grant in cpu cycle", 32'(0), 32'(my_gnt));
			check("cpu grant in cpu cycle", 32'(1), 32'(cpu_gnt));
			check("unmapped select", 32'(0), 32'(slv_stb));
		end
		cpu_req = '0;
		@(negedge wb_clk);	// grant one clock after cyc drops
		check("rk grant first", 32'(1), 32'(rk_gnt));
		check("my waits", 32'(0), 32'(my_gnt));
		check("cpu grant off", 32'(0), 32'(cpu_gnt));
		adr = 17'(take_bits(14) << 1);	// DRAM, user half
		dma_cycle(1'b0, adr, 1'b0, 2'b11, 16'h0000, req, rd);
		check("rk read data", 32'(16'o1000 + 16'(adr[8:1])), 32'(rd));
		rk_dma = 1'b0;
		@(negedge wb_clk);
		check("my grant next", 32'(1), 32'(my_gnt));
		check("rk grant off", 32'(0), 32'(rk_gnt));
		check("cpu still off", 32'(0), 32'(cpu_gnt));
		adr = 17'o177170 + 17'(take_bits(1) << 1);	// RX registers
		dma_cycle(1'b1, adr, 1'b0, 2'b11, 16'h0000, req, rd);
		check("my read data", 32'(16'o7000 + 16'(adr[8:1])), 32'(rd));
		my_dma = 1'b0;
		@(negedge wb_clk);
		check("my grant off", 32'(0), 32'(my_gnt));
		check("cpu grant back", 32'(1), 32'(cpu_gnt));
	endtask

	// new requests and lanes, then check grant and card lines a clock later
	task automatic sd_step(input logic [3:0] req, input logic [3:0] exp_gnt);
		mc_pkg::sd_lane_t l;
		sd_req  = req;
		sd_lane = 8'(take_bits(8));
		@(negedge wb_clk);
		l = sd_lane[0];	// idle card follows RK
		for (int i = 0; i < 4; i++)
			if (exp_gnt[i])
				l = sd_lane[i];
		check("sd grant", 32'(exp_gnt), 32'(sd_gnt));
		check("sd mosi", 32'(l.mosi), 32'(sd_mosi));
		check("sd cs", 32'(l.cs), 32'(sd_cs));
	endtask

	task automatic test_sd_sharing();
		test_name = "sd_sharing";
		sd_step(4'b1111, 4'b0001);	// RK wins
		sd_step(4'b1111, 4'b0001);
		sd_step(4'b1110, 4'b0000);	// release, clears a clock later
		sd_step(4'b1110, 4'b0010);
		sd_step(4'b1111, 4'b0010);	// DW held though RK is back
		sd_step(4'b1111, 4'b0010);
		sd_step(4'b1101, 4'b0000);
		sd_step(4'b1101, 4'b0001);
		sd_step(4'b1100, 4'b0000);
		sd_step(4'b1100, 4'b0100);	// DX
		sd_step(4'b1000, 4'b0000);
		sd_step(4'b1000, 4'b1000);	// MY last
		sd_step(4'b0000, 4'b0000);
		sd_step(4'b0000, 4'b0000);
	endtask

	task automatic vec_read(input logic [8:0] req, input logic una);
		logic [15:0] exp_dat;
		logic [8:0]  exp_ack;
		int          n;
		exp_dat = '0;
		exp_ack = '0;
		for (int i = 8; i >= 0; i--)
			if (req[i] && !una) begin
				exp_dat    = IRQ_VECS[i];
				exp_ack    = '0;
				exp_ack[i] = 1'b1;
			end
		if (una)
			exp_dat = 16'o140001;	// startup word
		irq_req = req;
		vec_una = una;
		vec_stb = 1'b1;
		n       = 0;
		do begin
			@(negedge wb_clk);
			n++;
			check("irq line", 32'(|req), 32'(vec_irq));
			if (n > WAIT_LIMIT)
				give_up("vector read got no ack");
		end while (!vec_ack);
		check("ack latency", 32'(1), 32'(n));
		check("vector", 32'(exp_dat), 32'(vec_dat));
		check("source ack", 32'(exp_ack), 32'(irq_ack));
		vec_stb = 1'b0;
		vec_una = 1'b0;
		@(negedge wb_clk);
		check("ack pulse", 32'(0), 32'(vec_ack));
		check("source ack pulse", 32'(0), 32'(irq_ack));
	endtask

	task automatic test_interrupts();
		test_name = "interrupts";
		vec_read(9'h000, 1'b0);	// nothing pending
		for (int i = 0; i < 9; i++)
			vec_read(9'(1) << i, 1'b0);	// every vector on its own
		for (int k = 0; k < 12; k++)
			vec_read(9'(take_bits(9)), 1'b0);
		vec_read(9'(take_bits(9)) | 9'h001, 1'b1);
		vec_read(9'h1ff, 1'b1);
		irq_req = '0;
	endtask

`endif

// ==== bench/tb_top.sv ====
/* testbench of the bus core: clock, reset, slave model, bus access helpers
   and the LFSR; runs the directed tests in order and reports the result */

`timescale 1ns/1ps

module tb_top;

	localparam int MAX_CYCLES = 4000;	// tests take ~350 cycles, wide margin
	localparam int WAIT_LIMIT = 20;	// per handshake

	logic                             wb_clk = 1'b0;
	logic                             rst_i;
	mc_pkg::wb_req_t                  cpu_req, rk_req, my_req, slv_req;
	mc_pkg::wb_rsp_t                  cpu_rsp, rk_rsp, my_rsp;
	logic                             cpu_gnt, rk_gnt, my_gnt, rk_dma, my_dma;
	mc_pkg::dev_vec_t                 slv_stb;
	mc_pkg::dev_vec_t                 slv_ack = '0;
	mc_pkg::dev_dat_t                 slv_dat;
	logic [3:0]                       sd_req, sd_gnt;
	mc_pkg::sd_lane_t [3:0]           sd_lane;
	logic                             sd_mosi, sd_cs;
	logic [8:0]                       irq_req, irq_ack;
	logic                             vec_stb, vec_una, vec_irq, vec_ack;
	logic [15:0]                      vec_dat;
	logic [31:0]                      lfsr_q = 32'h48c044e8;
	string                            test_name = "reset";
	int                               cycles = 0;

	always #10 wb_clk = ~wb_clk;	// 20 ns period

	mc_bus_top mc_bus_top_inst (
		.wb_clk(wb_clk), .rst_i(rst_i),
		.cpu_req_i(cpu_req), .cpu_rsp_o(cpu_rsp), .cpu_gnt_o(cpu_gnt),
		.rk_req_i(rk_req), .rk_dma_i(rk_dma), .rk_rsp_o(rk_rsp), .rk_gnt_o(rk_gnt),
		.my_req_i(my_req), .my_dma_i(my_dma), .my_rsp_o(my_rsp), .my_gnt_o(my_gnt),
		.slv_req_o(slv_req), .slv_stb_o(slv_stb), .slv_ack_i(slv_ack), .slv_dat_i(slv_dat),
		.sd_req_i(sd_req), .sd_lane_i(sd_lane), .sd_gnt_o(sd_gnt),
		.sd_mosi_o(sd_mosi), .sd_cs_o(sd_cs),
		.irq_req_i(irq_req), .irq_ack_o(irq_ack), .vec_stb_i(vec_stb), .vec_una_i(vec_una),
		.vec_irq_o(vec_irq), .vec_dat_o(vec_dat), .vec_ack_o(vec_ack)
	);

	//**********************************************************
	//* slave model
	//**********************************************************
	// one-cycle ack per access, one clock after the select
	always @(posedge wb_clk) begin
		if (rst_i)
			slv_ack <= '0;
		else
			slv_ack <= slv_stb & ~slv_ack;
	end

	// device index * 0o1000 + word address
	always_comb begin
		for (int i = 0; i < mc_pkg::N_DEV; i++)
			slv_dat[i] = 16'(i * 'o1000) + 16'(slv_req.adr[8:1]);
	end

	always @(posedge wb_clk) begin
		cycles <= cycles + 1;
		if (cycles > MAX_CYCLES)
			give_up("timeout, test sequence did not finish in time");
	end

	//**********************************************************
	//* helpers
	//**********************************************************
	task automatic give_up(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			give_up($sformatf("MISMATCH %s %s expected %h actual %h",
				test_name, what, exp, act));
	endtask

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int k = 0; k < n; k++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			r      = {r[30:0], lfsr_q[31]};
			lfsr_q = {lfsr_q[30:0], fb};
		end
		return r;
	endfunction

	// processor cycle, returns what the slaves saw at the ack
	task automatic cpu_access(input logic [16:0] adr, input logic we, input logic [1:0] sel,
		input logic [15:0] dat, output mc_pkg::dev_vec_t stb_seen,
		output mc_pkg::wb_req_t req_seen, output logic [15:0] rd);
		int n;
		n = 0;
		@(negedge wb_clk);
		cpu_req     = '0;
		cpu_req.adr = adr;
		cpu_req.dat = dat;
		cpu_req.we  = we;
		cpu_req.sel = sel;
		cpu_req.cyc = 1'b1;
		cpu_req.stb = 1'b1;
		do begin
			@(negedge wb_clk);
			n++;
			if (n > WAIT_LIMIT)
				give_up("processor cycle got no ack");
		end while (!cpu_rsp.ack);
		stb_seen = slv_stb;
		req_seen = slv_req;
		rd       = cpu_rsp.dat;
		cpu_req  = '0;	// end of cycle
	endtask

	task automatic wait_gnt(input logic is_my);
		int n;
		n = 0;
		do begin
			@(negedge wb_clk);
			n++;
			if (n > WAIT_LIMIT)
				give_up("DMA request was never granted");
		end while (!(is_my ? my_gnt : rk_gnt));
	endtask

	// DMA cycle on an already granted master
	task automatic dma_cycle(input logic is_my, input logic [16:0] adr, input logic we,
		input logic [1:0] sel, input logic [15:0] dat,
		output mc_pkg::wb_req_t req_seen, output logic [15:0] rd);
		mc_pkg::wb_req_t r;
		mc_pkg::wb_rsp_t rsp;
		int              n;
		r     = '0;
		r.adr = adr;
		r.dat = dat;
		r.we  = we;
		r.sel = sel;
		r.cyc = 1'b1;
		r.stb = 1'b1;
		n     = 0;
		@(negedge wb_clk);
		if (is_my)
			my_req = r;
		else
			rk_req = r;
		do begin
			@(negedge wb_clk);
			n++;
			check("cpu grant during DMA", 32'(0), 32'(cpu_gnt));
			check("cpu ack during DMA", 32'(0), 32'(cpu_rsp.ack));
			if (n > WAIT_LIMIT)
				give_up("DMA cycle got no ack");
			rsp = is_my ? my_rsp : rk_rsp;
		end while (!rsp.ack);
		check("other DMA ack", 32'(0), 32'(is_my ? rk_rsp.ack : my_rsp.ack));
		req_seen = slv_req;
		rd       = rsp.dat;
		rk_req   = '0;
		my_req   = '0;
	endtask

	`include "tb_tests.svh"

	//**********************************************************
	//* test sequence
	//**********************************************************
	initial begin
		cpu_req = '0;
		rk_req  = '0;
		my_req  = '0;
		rk_dma  = 1'b0;
		my_dma  = 1'b0;
		sd_req  = '0;
		sd_lane = '0;
		irq_req = '0;
		vec_stb = 1'b0;
		vec_una = 1'b0;
		rst_i   = 1'b1;
		repeat (16) @(posedge wb_clk);
		@(negedge wb_clk);
		rst_i = 1'b0;
		check("cpu grant", 32'(1), 32'(cpu_gnt));	// reset state
		check("dma grants", 32'(0), 32'({rk_gnt, my_gnt}));
		check("sd grant", 32'(0), 32'(sd_gnt));
		check("vector ack", 32'(0), 32'(vec_ack));
		check("source ack", 32'(0), 32'(irq_ack));
		test_decode();
		test_byte_lanes();
		test_arbitration();
		test_sd_sharing();
		test_interrupts();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== source/bus_master_arbiter.sv ====
/* bus master arbiter: hands the shared Wishbone bus to the processor or
   one of the RK/MY DMA engines, switching only between bus cycles */

`timescale 1ns/1ps

module bus_master_arbiter (
	input  logic            wb_clk,
	input  logic            rst_i,
	input  mc_pkg::wb_req_t cpu_req_i,	// processor
	input  mc_pkg::wb_req_t rk_req_i,	// RK11 DMA
	input  mc_pkg::wb_req_t my_req_i,	// MY DMA
	input  logic            rk_dma_i,	// raise-and-hold DMA requests
	input  logic            my_dma_i,
	input  mc_pkg::wb_rsp_t bus_rsp_i,	// from the decoder
	output mc_pkg::wb_req_t bus_req_o,
	output mc_pkg::wb_rsp_t cpu_rsp_o,
	output mc_pkg::wb_rsp_t rk_rsp_o,
	output mc_pkg::wb_rsp_t my_rsp_o,
	output logic            cpu_gnt_o,
	output logic            rk_gnt_o,
	output logic            my_gnt_o
);

	logic            rk_gnt_q;	// RK owns the bus
	logic            my_gnt_q;	// MY owns the bus
	mc_pkg::wb_req_t bus_req;

	//**********************************************************
	//* grant state
	//**********************************************************
	// owner may only change while no cycle is running
	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			rk_gnt_q <= 1'b0;
			my_gnt_q <= 1'b0;
		end else if (!bus_req.cyc) begin
			rk_gnt_q <= rk_dma_i;			// RK wins a tie
			my_gnt_q <= !rk_dma_i && my_dma_i;
		end
	end

	assign rk_gnt_o  = rk_gnt_q;
	assign my_gnt_o  = my_gnt_q;
	assign cpu_gnt_o = !(rk_gnt_q || my_gnt_q);	// cpu stalls while DMA holds

	//**********************************************************
	//* request and response steering
	//**********************************************************
	always_comb begin
		bus_req = cpu_req_i;
		if (rk_gnt_q) begin
			bus_req     = rk_req_i;
			bus_req.sel = '1;	// DMA is always word wide
		end else if (my_gnt_q) begin
			bus_req     = my_req_i;
			bus_req.sel = '1;
		end
	end

	assign bus_req_o = bus_req;

	// only the owner sees ack and data
	always_comb begin
		cpu_rsp_o = '0;
		rk_rsp_o  = '0;
		my_rsp_o  = '0;
		if (rk_gnt_q)
			rk_rsp_o = bus_rsp_i;
		else if (my_gnt_q)
			my_rsp_o = bus_rsp_i;
		else
			cpu_rsp_o = bus_rsp_i;
	end

	// never two DMA owners
	a_dma_excl: assert property (@(posedge wb_clk) disable iff (rst_i)
		!(rk_gnt_q && my_gnt_q));

endmodule

// ==== source/io_page_decoder.sv ====
/* address decoder of the system bus: forms the slave selects from the
   device map, maps dynamic memory and ROM, merges slave acks and read data */

`timescale 1ns/1ps

module io_page_decoder (
	input  logic             wb_clk,	// assertion clock only
	input  logic             rst_i,
	input  mc_pkg::wb_req_t  bus_req_i,
	input  mc_pkg::dev_vec_t slv_ack_i,
	input  mc_pkg::dev_dat_t slv_dat_i,
	output mc_pkg::dev_vec_t slv_stb_o,
	output mc_pkg::wb_rsp_t  bus_rsp_o
);

	logic [mc_pkg::ADR_W-1:0] adr;
	mc_pkg::dev_vec_t         sel;	// address match, before strobe gating
	logic [mc_pkg::DAT_W-1:0] rd_dat;

	// register window compare, low bits ignored
	function automatic logic io_hit(
		input logic [mc_pkg::ADR_W-1:0] a,
		input logic [mc_pkg::ADR_W-1:0] base,
		input int                       shift
	);
		return (a >> shift) == (base >> shift);
	endfunction

	assign adr = bus_req_i.adr;

	//**********************************************************
	//* device selects
	//**********************************************************
	always_comb begin
		sel = '0;
		// monitor ROM in the shadow area
		sel[mc_pkg::DEV_ROM] = io_hit(adr, mc_pkg::BASE_ROM, mc_pkg::SHIFT_ROM);
		// user mode (bit 16 low) sees 000000-157776,
		// console mode (bit 16 high) sees only the 160000 page
		sel[mc_pkg::DEV_DRAM] = (adr[15:13] != 3'b111) ^ adr[16];
		sel[mc_pkg::DEV_UART1] = io_hit(adr, mc_pkg::BASE_UART1, mc_pkg::SHIFT_UART1);
		sel[mc_pkg::DEV_UART2] = io_hit(adr, mc_pkg::BASE_UART2, mc_pkg::SHIFT_UART2);
		sel[mc_pkg::DEV_RK]    = io_hit(adr, mc_pkg::BASE_RK, mc_pkg::SHIFT_RK);
		sel[mc_pkg::DEV_LPT]   = io_hit(adr, mc_pkg::BASE_LPT, mc_pkg::SHIFT_LPT);
		sel[mc_pkg::DEV_DW]    = io_hit(adr, mc_pkg::BASE_DW, mc_pkg::SHIFT_DW);
		sel[mc_pkg::DEV_RX]    = io_hit(adr, mc_pkg::BASE_RX, mc_pkg::SHIFT_RX);
		sel[mc_pkg::DEV_MY]    = io_hit(adr, mc_pkg::BASE_MY, mc_pkg::SHIFT_MY);
		sel[mc_pkg::DEV_KGD]   = io_hit(adr, mc_pkg::BASE_KGD, mc_pkg::SHIFT_KGD);
	end

	// strobes only inside an active transfer
	assign slv_stb_o = (bus_req_i.stb && bus_req_i.cyc) ? sel : '0;

	//**********************************************************
	//* return path
	//**********************************************************
	// read data from whichever device is selected
	always_comb begin
		rd_dat = '0;
		for (int i = 0; i < mc_pkg::N_DEV; i++)
			if (slv_stb_o[i])
				rd_dat = rd_dat | slv_dat_i[i];
	end

	assign bus_rsp_o.dat = rd_dat;
	assign bus_rsp_o.ack = |slv_ack_i;	// wired-or of all slave acks

	// device map must not overlap
	a_one_sel: assert property (@(posedge wb_clk) disable iff (rst_i)
		$onehot0(slv_stb_o));

endmodule

// ==== source/mc_bus_top.sv ====
/* system-bus core of the MC1201.02 board: master arbitration, address
   decoding, SD-card sharing and vectored interrupts behind one port list */

`timescale 1ns/1ps

module mc_bus_top (
	input  logic                                wb_clk,
	input  logic                                rst_i,
	// processor and DMA masters
	input  mc_pkg::wb_req_t                     cpu_req_i,
	output mc_pkg::wb_rsp_t                     cpu_rsp_o,
	output logic                                cpu_gnt_o,
	input  mc_pkg::wb_req_t                     rk_req_i,
	input  logic                                rk_dma_i,
	output mc_pkg::wb_rsp_t                     rk_rsp_o,
	output logic                                rk_gnt_o,
	input  mc_pkg::wb_req_t                     my_req_i,
	input  logic                                my_dma_i,
	output mc_pkg::wb_rsp_t                     my_rsp_o,
	output logic                                my_gnt_o,
	// slaves
	output mc_pkg::wb_req_t                     slv_req_o,
	output mc_pkg::dev_vec_t                    slv_stb_o,
	input  mc_pkg::dev_vec_t                    slv_ack_i,
	input  mc_pkg::dev_dat_t                    slv_dat_i,
	// SD card
	input  logic [mc_pkg::N_SD-1:0]             sd_req_i,
	input  mc_pkg::sd_lane_t [mc_pkg::N_SD-1:0] sd_lane_i,
	output logic [mc_pkg::N_SD-1:0]             sd_gnt_o,
	output logic                                sd_mosi_o,
	output logic                                sd_cs_o,
	// interrupts
	input  logic [mc_pkg::N_IRQ-1:0]            irq_req_i,
	output logic [mc_pkg::N_IRQ-1:0]            irq_ack_o,
	input  logic                                vec_stb_i,
	input  logic                                vec_una_i,
	output logic                                vec_irq_o,
	output logic [mc_pkg::DAT_W-1:0]            vec_dat_o,
	output logic                                vec_ack_o
);

	mc_pkg::wb_req_t bus_req;	// owner's request on the shared bus
	mc_pkg::wb_rsp_t bus_rsp;

	assign slv_req_o = bus_req;

	//**********************************************************
	//* bus masters and slaves
	//**********************************************************
	bus_master_arbiter bus_master_arbiter_inst (
		.wb_clk    (wb_clk),
		.rst_i     (rst_i),
		.cpu_req_i (cpu_req_i),
		.rk_req_i  (rk_req_i),
		.my_req_i  (my_req_i),
		.rk_dma_i  (rk_dma_i),
		.my_dma_i  (my_dma_i),
		.bus_rsp_i (bus_rsp),
		.bus_req_o (bus_req),
		.cpu_rsp_o (cpu_rsp_o),
		.rk_rsp_o  (rk_rsp_o),
		.my_rsp_o  (my_rsp_o),
		.cpu_gnt_o (cpu_gnt_o),
		.rk_gnt_o  (rk_gnt_o),
		.my_gnt_o  (my_gnt_o)
	);

	io_page_decoder io_page_decoder_inst (
		.wb_clk    (wb_clk),
		.rst_i     (rst_i),
		.bus_req_i (bus_req),
		.slv_ack_i (slv_ack_i),
		.slv_dat_i (slv_dat_i),
		.slv_stb_o (slv_stb_o),
		.bus_rsp_o (bus_rsp)
	);

	//**********************************************************
	//* SD card and interrupts
	//**********************************************************
	sd_card_arbiter sd_card_arbiter_inst (
		.wb_clk    (wb_clk),
		.rst_i     (rst_i),
		.sd_req_i  (sd_req_i),
		.sd_lane_i (sd_lane_i),
		.sd_gnt_o  (sd_gnt_o),
		.sd_mosi_o (sd_mosi_o),
		.sd_cs_o   (sd_cs_o)
	);

	vector_irq_ctrl vector_irq_ctrl_inst (
		.wb_clk    (wb_clk),
		.rst_i     (rst_i),
		.irq_req_i (irq_req_i),
		.vec_stb_i (vec_stb_i),
		.vec_una_i (vec_una_i),
		.vec_irq_o (vec_irq_o),
		.vec_dat_o (vec_dat_o),
		.vec_ack_o (vec_ack_o),
		.irq_ack_o (irq_ack_o)
	);

endmodule

// ==== source/mc_pkg.sv ====
/* shared definitions of the MC1201.02 bus core: bus structs, device map,
   interrupt vectors and widths, referenced by scoped name from RTL and bench */

package mc_pkg;

	//**********************************************************
	//* bus widths and transfer structs
	//**********************************************************
	localparam int ADR_W = 17;	// 16-bit address plus console/user bit
	localparam int DAT_W = 16;
	localparam int SEL_W = 2;	// byte lanes

	// request as driven by one master
	typedef struct packed {
		logic [ADR_W-1:0] adr;
		logic [DAT_W-1:0] dat;	// write data
		logic             cyc;
		logic             we;	// 1 - write from master
		logic [SEL_W-1:0] sel;
		logic             stb;
	} wb_req_t;

	// response back to a master
	typedef struct packed {
		logic [DAT_W-1:0] dat;	// read data
		logic             ack;
	} wb_rsp_t;

	// one SD-card client lane
	typedef struct packed {
		logic mosi;
		logic cs;
	} sd_lane_t;

	//**********************************************************
	//* slave devices
	//**********************************************************
	typedef enum logic [3:0] {
		DEV_ROM, DEV_DRAM, DEV_UART1, DEV_UART2, DEV_RK,
		DEV_LPT, DEV_DW, DEV_RX, DEV_MY, DEV_KGD
	} dev_e;

	localparam int N_DEV = 10;
	typedef logic [N_DEV-1:0] dev_vec_t;	// selects, acks
	typedef logic [N_DEV-1:0][DAT_W-1:0] dev_dat_t;

	// base addresses and number of low bits ignored by the compare
	localparam logic [ADR_W-1:0] BASE_ROM   = 17'o340000;	// shadow window, bits 16:13 = 1110
	localparam int               SHIFT_ROM  = 13;
	localparam logic [ADR_W-1:0] BASE_UART1 = 17'o177560;	// console
	localparam int               SHIFT_UART1 = 3;
	localparam logic [ADR_W-1:0] BASE_UART2 = 17'o176500;
	localparam int               SHIFT_UART2 = 3;
	localparam logic [ADR_W-1:0] BASE_LPT   = 17'o177514;
	localparam int               SHIFT_LPT  = 2;
	localparam logic [ADR_W-1:0] BASE_RK    = 17'o177400;
	localparam int               SHIFT_RK   = 4;
	localparam logic [ADR_W-1:0] BASE_DW    = 17'o174000;
	localparam int               SHIFT_DW   = 5;
	localparam logic [ADR_W-1:0] BASE_RX    = 17'o177170;
	localparam int               SHIFT_RX   = 2;
	localparam logic [ADR_W-1:0] BASE_MY    = 17'o172140;
	localparam int               SHIFT_MY   = 2;
	localparam logic [ADR_W-1:0] BASE_KGD   = 17'o176640;	// graphics
	localparam int               SHIFT_KGD  = 3;

	//**********************************************************
	//* interrupts, index 0 has the highest priority
	//**********************************************************
	localparam int N_IRQ = 9;
	// MY, RX, DW, printer, RK, UART2 rx/tx, UART1 rx/tx
	localparam logic [N_IRQ-1:0][DAT_W-1:0] IRQ_VEC = {
		16'o000170, 16'o000264, 16'o000300, 16'o000200, 16'o000220,
		16'o000330, 16'o000334, 16'o000060, 16'o000064
	};
	localparam logic [DAT_W-1:0] STARTUP_WORD = 16'o140001;	// address-less read

	// SD-card clients, lane order RK, DW, DX, MY
	localparam int N_SD  = 4;
	localparam int SD_RK = 0;	// default owner of the card lines

endpackage

// ==== source/sd_card_arbiter.sv ====
/* SD-card arbiter: one disk controller at a time owns the card, held until
   it drops its request; the owner's MOSI and chip select drive the card */

`timescale 1ns/1ps

module sd_card_arbiter (
	input  logic                                  wb_clk,
	input  logic                                  rst_i,
	input  logic [mc_pkg::N_SD-1:0]               sd_req_i,	// RK, DW, DX, MY
	input  mc_pkg::sd_lane_t [mc_pkg::N_SD-1:0]   sd_lane_i,
	output logic [mc_pkg::N_SD-1:0]               sd_gnt_o,
	output logic                                  sd_mosi_o,
	output logic                                  sd_cs_o
);

	logic [mc_pkg::N_SD-1:0] gnt_q;
	logic [mc_pkg::N_SD-1:0] first_req;	// lowest-index requester
	mc_pkg::sd_lane_t        lane;

	// fixed priority, lowest index wins
	always_comb begin
		first_req = '0;
		for (int i = mc_pkg::N_SD - 1; i >= 0; i--) begin
			if (sd_req_i[i]) begin
				first_req    = '0;
				first_req[i] = 1'b1;
			end
		end
	end

	//**********************************************************
	//* grant
	//**********************************************************
	always_ff @(posedge wb_clk) begin
		if (rst_i)
			gnt_q <= '0;
		else if (gnt_q == '0)
			gnt_q <= first_req;			// idle, look for a client
		else if ((gnt_q & sd_req_i) == '0)
			gnt_q <= '0;				// owner let go
	end

	assign sd_gnt_o = gnt_q;

	//**********************************************************
	//* card line mux
	//**********************************************************
	always_comb begin
		lane = sd_lane_i[mc_pkg::SD_RK];	// RK lane when nobody owns it
		for (int i = 0; i < mc_pkg::N_SD; i++)
			if (gnt_q[i])
				lane = sd_lane_i[i];
	end

	assign sd_mosi_o = lane.mosi;
	assign sd_cs_o   = lane.cs;

	a_gnt_onehot: assert property (@(posedge wb_clk) disable iff (rst_i)
		$onehot0(gnt_q));

endmodule

// ==== source/vector_irq_ctrl.sv ====
/* vectored interrupt controller: on a vector read returns the vector of the
   highest-priority request and acks that source, or the startup word on an
   address-less read */

`timescale 1ns/1ps

module vector_irq_ctrl (
	input  logic                     wb_clk,
	input  logic                     rst_i,
	input  logic [mc_pkg::N_IRQ-1:0] irq_req_i,	// level requests
	input  logic                     vec_stb_i,	// vector read strobe
	input  logic                     vec_una_i,	// address-less read
	output logic                     vec_irq_o,
	output logic [mc_pkg::DAT_W-1:0] vec_dat_o,
	output logic                     vec_ack_o,
	output logic [mc_pkg::N_IRQ-1:0] irq_ack_o
);

	logic [mc_pkg::N_IRQ-1:0] first_req;	// one-hot winner
	logic [mc_pkg::DAT_W-1:0] pick_vec;	// its vector, zero if none
	logic                     ack_q;
	logic                     done_q;	// answered, wait for strobe low
	logic [mc_pkg::N_IRQ-1:0] irq_ack_q;
	logic [mc_pkg::DAT_W-1:0] dat_q;

	assign vec_irq_o = |irq_req_i;	// straight to the processor

	//**********************************************************
	//* priority encoder
	//**********************************************************
	// walk down so index 0 ends up on top
	always_comb begin
		first_req = '0;
		pick_vec  = '0;
		for (int i = mc_pkg::N_IRQ - 1; i >= 0; i--) begin
			if (irq_req_i[i]) begin
				first_req    = '0;
				first_req[i] = 1'b1;
				pick_vec     = mc_pkg::IRQ_VEC[i];
			end
		end
	end

	//**********************************************************
	//* vector read handshake
	//**********************************************************
	always_ff @(posedge wb_clk) begin
		if (rst_i) begin
			ack_q     <= 1'b0;
			done_q    <= 1'b0;
			irq_ack_q <= '0;
		end else begin
			ack_q     <= 1'b0;		// single-cycle pulses
			irq_ack_q <= '0;
			if (!vec_stb_i)
				done_q <= 1'b0;
			else if (!done_q) begin
				ack_q  <= 1'b1;
				done_q <= 1'b1;
				// startup read leaves the sources alone
				irq_ack_q <= vec_una_i ? '0 : first_req;
			end
		end
	end

	// data word latched with the ack
	always_ff @(posedge wb_clk) begin
		if (vec_stb_i && !done_q)
			dat_q <= vec_una_i ? mc_pkg::STARTUP_WORD : pick_vec;
	end

	assign vec_ack_o = ack_q;
	assign vec_dat_o = dat_q;
	assign irq_ack_o = irq_ack_q;

	// a source ack only rides along with the vector ack
	a_iack: assert property (@(posedge wb_clk) disable iff (rst_i)
		$onehot0(irq_ack_o) && (irq_ack_o == '0 || vec_ack_o));

endmodule
